// ==== hw/lc3b_types.sv ====
// LC-3b widths throughout; LC-3X ops ride on the RTI opcode, selected by ir[5:3]
`default_nettype none

package lc3b_types;

    localparam int NUM_REGS = 8;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,  // LC-3X ops
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [3:0] {
        alu_passa,
        alu_passb,
        alu_add,
        alu_and,
        alu_nand,
        alu_not,
        alu_sub,
        alu_xor,
        alu_or,
        alu_div,
        alu_mult
    } lc3b_aluop;

    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_aluop  aluop;
        // datapath mux selects
        logic       addr1mux_sel;
        logic [1:0] addr2mux_sel;
        logic       addr3mux_sel;
        logic       lshf;
        logic       sr2mux_sel;         // imm5 instead of sr2
        logic       storemux_sel;       // sr2 taken from ir[11:9]
        logic [1:0] wbmux_sel;
        logic       dest_mux_sel;       // dr forced to R7
        logic [1:0] alu_result_mux_sel;
        logic       d_mem_byte_sel;
        // op flags
        logic       br_op;
        logic       jsr_op;
        logic       jmp_op;
        logic       trap_op;
        logic       uncond_op;
        logic       stb_op;
        logic       ldi_op;
        logic       sti_op;
        logic       ldb_op;
        logic       div_op;
        logic       mult_op;
        logic       sub_op;
        logic       xor_op;
        logic       or_op;
        logic       nor_op;
        logic       xnor_op;
        logic       nand_op;
        logic       ldbse_op;
        logic       load_reg;
        logic       load_cc;
        logic       dcache_enable;
        logic       dcacheR;
        logic       dcacheW;
        // hazard inputs
        logic       sr1_needed;
        logic       sr2_needed;
        logic       dr_needed;
        lc3b_word   pc;
    } lc3b_control_word;

    typedef struct packed {
        lc3b_word pc;
        lc3b_word ir;
    } lc3b_fetch_t;

    typedef struct packed {
        lc3b_control_word ctrl;
        lc3b_word         ir;
        lc3b_word         sr1_data;
        lc3b_word         sr2_data;
        lc3b_reg          dr;
    } lc3b_decoded_t;

endpackage : lc3b_types

`default_nettype wire

// ==== hw/pipe_reg.sv ====
// one entry deep; payload is not reset, only the valid flag is
`default_nettype none

module pipe_reg
#(
    parameter type payload_t = logic
)
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // empty, or draining in this same cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            out_valid <= 1'b0;
        else if (in_ready)
            out_valid <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        if (in_ready && in_valid)
            out_data <= in_data;
    end

    // a stalled entry must not move or vanish
    a_hold_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    );

endmodule : pipe_reg

`default_nettype wire

// ==== hw/control_rom.sv ====
// purely combinational; nor and xnor carry only their op flag, aluop stays pass a
`default_nettype none

module control_rom
(
    input  lc3b_types::lc3b_opcode       opcode,
    input  logic                         ir11,
    input  logic                         ir4,
    input  logic                         ir5,
    input  logic [2:0]                   lc3x_control,
    input  lc3b_types::lc3b_word         pc,
    output lc3b_types::lc3b_control_word ctrl
);

    import lc3b_types::*;

    always_comb
    begin
        ctrl        = '0;   // everything off unless an opcode asks
        ctrl.opcode = opcode;
        ctrl.aluop  = alu_passa;
        ctrl.pc     = pc;

        case (opcode)
            op_add, op_and:
            begin
                if (opcode == op_add)
                    ctrl.aluop = alu_add;
                else if (ir4)
                    ctrl.aluop = alu_nand;  // LC-3X nand
                else
                    ctrl.aluop = alu_and;
                ctrl.nand_op    = (opcode == op_and) && ir4;
                ctrl.load_reg   = 1'b1;
                ctrl.load_cc    = 1'b1;
                ctrl.wbmux_sel  = 2'b11;
                ctrl.sr1_needed = 1'b1;
                ctrl.sr2_needed = !ir5;     // imm5 form has no sr2
                ctrl.sr2mux_sel = ir5;
                ctrl.dr_needed  = 1'b1;
            end

            op_not, op_shf:
            begin
                ctrl.aluop              = (opcode == op_not) ? alu_not : alu_passa;
                ctrl.alu_result_mux_sel = (opcode == op_shf) ? 2'b01 : 2'b00;
                ctrl.load_reg           = 1'b1;
                ctrl.load_cc            = 1'b1;
                ctrl.wbmux_sel          = 2'b11;
                ctrl.sr1_needed         = 1'b1;
                ctrl.dr_needed          = 1'b1;
            end

            op_ldr, op_ldb, op_ldi:
            begin
                ctrl.addr1mux_sel   = 1'b1;
                ctrl.addr2mux_sel   = 2'b01;    // base + offset6
                ctrl.lshf           = (opcode != op_ldb);
                ctrl.wbmux_sel      = 2'b01;
                ctrl.load_reg       = 1'b1;
                ctrl.load_cc        = 1'b1;
                ctrl.dcache_enable  = 1'b1;
                ctrl.dcacheR        = 1'b1;
                ctrl.d_mem_byte_sel = (opcode == op_ldb);
                ctrl.ldb_op         = (opcode == op_ldb);
                ctrl.ldi_op         = (opcode == op_ldi);
                ctrl.sr1_needed     = 1'b1;
                ctrl.dr_needed      = 1'b1;
            end

            op_str, op_stb, op_sti:
            begin
                ctrl.aluop         = alu_passb;  // store data goes through the ALU
                ctrl.addr1mux_sel  = 1'b1;
                ctrl.addr2mux_sel  = 2'b01;
                ctrl.lshf          = (opcode != op_stb);
                ctrl.storemux_sel  = 1'b1;
                ctrl.dcache_enable = 1'b1;
                ctrl.dcacheW       = 1'b1;
                ctrl.stb_op        = (opcode == op_stb);
                ctrl.sti_op        = (opcode == op_sti);
                ctrl.sr1_needed    = 1'b1;
                ctrl.dr_needed     = 1'b1;      // source register sits in the dr field
            end

            op_br:
            begin
                ctrl.addr2mux_sel = 2'b10;
                ctrl.lshf         = 1'b1;
                ctrl.br_op        = 1'b1;
            end

            op_lea:
            begin
                ctrl.addr2mux_sel = 2'b10;
                ctrl.lshf         = 1'b1;
                ctrl.storemux_sel = 1'b1;
                ctrl.load_reg     = 1'b1;
                ctrl.load_cc      = 1'b1;
                ctrl.dr_needed    = 1'b1;
            end

            op_jmp:
            begin
                ctrl.jmp_op     = 1'b1;     // ret as well
                ctrl.uncond_op  = 1'b1;
                ctrl.sr1_needed = 1'b1;
            end

            op_jsr:
            begin
                ctrl.dest_mux_sel = 1'b1;   // link into R7
                ctrl.wbmux_sel    = 2'b10;
                ctrl.load_reg     = 1'b1;
                ctrl.uncond_op    = 1'b1;
                if (ir11)
                begin
                    ctrl.jsr_op       = 1'b1;
                    ctrl.br_op        = 1'b1;
                    ctrl.addr2mux_sel = 2'b11;  // pc + offset11
                    ctrl.lshf         = 1'b1;
                end
                else
                begin
                    ctrl.jmp_op     = 1'b1;     // jsrr, target from base register
                    ctrl.sr1_needed = 1'b1;
                end
            end

            op_trap:
            begin
                ctrl.dest_mux_sel  = 1'b1;
                ctrl.wbmux_sel     = 2'b10;
                ctrl.load_reg      = 1'b1;
                ctrl.trap_op       = 1'b1;
                ctrl.uncond_op     = 1'b1;
                ctrl.addr3mux_sel  = 1'b1;  // zext trapvect8 << 1
                ctrl.dcache_enable = 1'b1;
                ctrl.dcacheR       = 1'b1;
            end

            op_rti:
            begin
                ctrl.load_reg  = 1'b1;
                ctrl.load_cc   = 1'b1;
                ctrl.dr_needed = 1'b1;
                ctrl.sr1_needed = 1'b1;
                if (lc3x_control == 3'b111)
                begin
                    // ldbse, byte load path
                    ctrl.ldbse_op       = 1'b1;
                    ctrl.ldb_op         = 1'b1;
                    ctrl.addr1mux_sel   = 1'b1;
                    ctrl.addr2mux_sel   = 2'b01;
                    ctrl.wbmux_sel      = 2'b01;
                    ctrl.dcache_enable  = 1'b1;
                    ctrl.dcacheR        = 1'b1;
                    ctrl.d_mem_byte_sel = 1'b1;
                end
                else
                begin
                    ctrl.wbmux_sel  = 2'b11;
                    ctrl.sr2_needed = 1'b1;
                end
                case (lc3x_control)
                    3'b000:  begin ctrl.div_op  = 1'b1; ctrl.aluop = alu_div;  end
                    3'b001:  begin ctrl.mult_op = 1'b1; ctrl.aluop = alu_mult; end
                    3'b010:  begin ctrl.sub_op  = 1'b1; ctrl.aluop = alu_sub;  end
                    3'b011:  begin ctrl.xor_op  = 1'b1; ctrl.aluop = alu_xor;  end
                    3'b100:  begin ctrl.or_op   = 1'b1; ctrl.aluop = alu_or;   end
                    3'b101:  ctrl.nor_op  = 1'b1;
                    3'b110:  ctrl.xnor_op = 1'b1;
                    default: ctrl.aluop   = alu_passa;  // ldbse handled above
                endcase
            end

            default: ctrl = '0;     // unknown opcode
        endcase
    end

endmodule : control_rom

`default_nettype wire

// ==== hw/regfile.sv ====
// no write-to-read bypass; a write shows on the read ports one cycle later
`default_nettype none

module regfile
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  lc3b_types::lc3b_reg  sr1,
    input  lc3b_types::lc3b_reg  sr2,
    output lc3b_types::lc3b_word sr1_data,
    output lc3b_types::lc3b_word sr2_data,
    input  logic                 wr_en,
    input  lc3b_types::lc3b_reg  wr_reg,
    input  lc3b_types::lc3b_word wr_data
);

    import lc3b_types::*;

    lc3b_word regs [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (wr_en)
            regs[wr_reg] <= wr_data;
    end

    assign sr1_data = regs[sr1];
    assign sr2_data = regs[sr2];

endmodule : regfile

`default_nettype wire

// ==== hw/scoreboard.sv ====
// one writer per register in flight; writeback must target a busy register
`default_nettype none

module scoreboard
(
    input  logic                clk,
    input  logic                arst_n,
    input  logic                set_en,
    input  lc3b_types::lc3b_reg set_reg,
    input  logic                clr_en,
    input  lc3b_types::lc3b_reg clr_reg,
    input  lc3b_types::lc3b_reg sr1,
    input  lc3b_types::lc3b_reg sr2,
    input  lc3b_types::lc3b_reg dr,
    input  logic                sr1_needed,
    input  logic                sr2_needed,
    input  logic                dr_needed,
    output logic                hazard
);

    import lc3b_types::*;

    logic [NUM_REGS-1:0] busy;  // pending writeback per register

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            busy <= '0;
        else
        begin
            if (clr_en)
                busy[clr_reg] <= 1'b0;
            if (set_en)
                busy[set_reg] <= 1'b1;
        end
    end

    assign hazard = (sr1_needed && busy[sr1]) ||
                    (sr2_needed && busy[sr2]) ||
                    (dr_needed  && busy[dr]);   // waw too

    // every writeback pairs with an earlier issue
    a_clr_busy: assert property (
        @(posedge clk) disable iff (!arst_n) clr_en |-> busy[clr_reg]
    );

    a_set_free: assert property (
        @(posedge clk) disable iff (!arst_n) set_en |-> !busy[set_reg]
    );

endmodule : scoreboard

`default_nettype wire

// ==== hw/decode_core.sv ====
// combinational between the stage registers; stalls instead of forwarding
`default_nettype none

module decode_core
(
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      fetch_valid,
    output logic                      fetch_ready,
    input  lc3b_types::lc3b_fetch_t   fetch_data,
    output logic                      dec_valid,
    input  logic                      dec_ready,
    output lc3b_types::lc3b_decoded_t dec_data,
    input  logic                      wb_valid,
    input  lc3b_types::lc3b_reg       wb_dr,
    input  lc3b_types::lc3b_word      wb_data
);

    import lc3b_types::*;

    lc3b_word         ir;
    lc3b_control_word ctrl;
    lc3b_reg          sr1;
    lc3b_reg          sr2;
    lc3b_reg          dr;
    lc3b_word         sr1_data;
    lc3b_word         sr2_data;
    logic             hazard;

    assign ir = fetch_data.ir;

    control_rom control_rom_i (
        .opcode       (lc3b_opcode'(ir[15:12])),
        .ir11         (ir[11]),
        .ir4          (ir[4]),
        .ir5          (ir[5]),
        .lc3x_control (ir[5:3]),
        .pc           (fetch_data.pc),
        .ctrl         (ctrl)
    );

    assign sr1 = ir[8:6];
    assign sr2 = ctrl.storemux_sel ? ir[11:9] : ir[2:0];   // stores read ir[11:9]
    assign dr  = ctrl.dest_mux_sel ? 3'd7 : ir[11:9];       // R7 link for jsr/trap

    regfile regfile_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .sr1      (sr1),
        .sr2      (sr2),
        .sr1_data (sr1_data),
        .sr2_data (sr2_data),
        .wr_en    (wb_valid),
        .wr_reg   (wb_dr),
        .wr_data  (wb_data)
    );

    // destination is checked whenever it will be written
    scoreboard scoreboard_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .set_en     (dec_valid && dec_ready && ctrl.load_reg),
        .set_reg    (dr),
        .clr_en     (wb_valid),
        .clr_reg    (wb_dr),
        .sr1        (sr1),
        .sr2        (sr2),
        .dr         (dr),
        .sr1_needed (ctrl.sr1_needed),
        .sr2_needed (ctrl.sr2_needed),
        .dr_needed  (ctrl.dr_needed || ctrl.load_reg),
        .hazard     (hazard)
    );

    assign dec_valid   = fetch_valid && !hazard;
    assign fetch_ready = dec_ready && !hazard;

    assign dec_data.ctrl     = ctrl;
    assign dec_data.ir       = ir;
    assign dec_data.sr1_data = sr1_data;
    assign dec_data.sr2_data = sr2_data;
    assign dec_data.dr       = dr;

endmodule : decode_core

`default_nettype wire

// ==== hw/decode_stage.sv ====
// writeback is always accepted; two cycles input to output without stalls
`default_nettype none

module decode_stage
(
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         in_valid,
    output logic                         in_ready,
    input  lc3b_types::lc3b_word         in_pc,
    input  lc3b_types::lc3b_word         in_ir,
    output logic                         out_valid,
    input  logic                         out_ready,
    output lc3b_types::lc3b_word         out_pc,
    output lc3b_types::lc3b_word         out_ir,
    output lc3b_types::lc3b_control_word out_ctrl,
    output lc3b_types::lc3b_word         out_sr1_data,
    output lc3b_types::lc3b_word         out_sr2_data,
    output lc3b_types::lc3b_reg          out_dr,
    input  logic                         wb_valid,
    input  lc3b_types::lc3b_reg          wb_dr,
    input  lc3b_types::lc3b_word         wb_data
);

    import lc3b_types::*;

    lc3b_fetch_t   in_data;
    lc3b_fetch_t   fetch_data;
    logic          fetch_valid;
    logic          fetch_ready;
    lc3b_decoded_t dec_data;
    lc3b_decoded_t out_data;
    logic          dec_valid;
    logic          dec_ready;

    assign in_data.pc = in_pc;
    assign in_data.ir = in_ir;

    pipe_reg #(.payload_t(lc3b_fetch_t)) fetch_reg_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (fetch_valid),
        .out_ready (fetch_ready),
        .out_data  (fetch_data)
    );

    decode_core decode_core_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch_data  (fetch_data),
        .dec_valid   (dec_valid),
        .dec_ready   (dec_ready),
        .dec_data    (dec_data),
        .wb_valid    (wb_valid),
        .wb_dr       (wb_dr),
        .wb_data     (wb_data)
    );

    pipe_reg #(.payload_t(lc3b_decoded_t)) out_reg_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (dec_valid),
        .in_ready  (dec_ready),
        .in_data   (dec_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    assign out_pc       = out_data.ctrl.pc;    // pc travels inside the control word
    assign out_ir       = out_data.ir;
    assign out_ctrl     = out_data.ctrl;
    assign out_sr1_data = out_data.sr1_data;
    assign out_sr2_data = out_data.sr2_data;
    assign out_dr       = out_data.dr;

endmodule : decode_stage

`default_nettype wire

// ==== test/tb_clock.sv ====
// free-running clock from time zero; reset released on a falling edge after RESET_CYCLES
`default_nettype none

module tb_clock
#(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 8
)
(
    output logic clk,
    output logic arst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;  // clear of any edge
    end

endmodule : tb_clock

`default_nettype wire

// ==== test/decode_stage_tb.sv ====
// in-order execute model; expected source values assume one writer per register in flight
`default_nettype none

module decode_stage_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import lc3b_types::*;

    localparam int N_ENTRIES    = 25;
    localparam int RESET_CYCLES = 8;
    localparam int LIMIT        = RESET_CYCLES + 20 * N_ENTRIES;

    typedef struct packed {
        lc3b_word  ir;
        lc3b_word  pc;
        lc3b_aluop aluop;
        logic      load_reg;
        logic      load_cc;
        logic [1:0] wbmux;
        logic      dcr;
        logic      dcw;
        logic      uncond;
        logic [7:0] xflags;     // div mult sub xor or nor xnor ldbse
        lc3b_reg   dr;
        lc3b_reg   sr1;
        lc3b_reg   sr2;
        logic      chk1;
        logic      chk2;
        lc3b_word  sr1_val;
        lc3b_word  sr2_val;
        lc3b_word  result;
    } entry_t;

    logic clk;
    logic arst_n;
    logic in_valid;
    logic in_ready;
    lc3b_word in_pc;
    lc3b_word in_ir;
    logic out_valid;
    logic out_ready;
    lc3b_word out_pc;
    lc3b_word out_ir;
    lc3b_control_word out_ctrl;
    lc3b_word out_sr1_data;
    lc3b_word out_sr2_data;
    lc3b_reg out_dr;
    logic wb_valid;
    lc3b_reg wb_dr;
    lc3b_word wb_data;

    entry_t   tbl [N_ENTRIES];
    lc3b_word build_model [NUM_REGS];
    lc3b_word live_model [NUM_REGS];
    int       n_built;
    logic [31:0] rng;

    lc3b_reg  wbq_dr [$];
    lc3b_word wbq_data [$];
    int       wbq_due [$];

    int   cycles;
    int   n_out;
    int   errors;
    int   tests_failed;
    logic started;
    logic test_bad;
    logic held;
    logic [$bits(lc3b_control_word)+66:0] snap;

    tb_clock #(.PERIOD(20), .RESET_CYCLES(RESET_CYCLES)) tb_clock_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    decode_stage decode_stage_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_pc        (in_pc),
        .in_ir        (in_ir),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_pc       (out_pc),
        .out_ir       (out_ir),
        .out_ctrl     (out_ctrl),
        .out_sr1_data (out_sr1_data),
        .out_sr2_data (out_sr2_data),
        .out_dr       (out_dr),
        .wb_valid     (wb_valid),
        .wb_dr        (wb_dr),
        .wb_data      (wb_data)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic lc3b_word enc_reg(input logic [3:0] op, input lc3b_reg d,
                                         input lc3b_reg a, input logic [2:0] mid,
                                         input lc3b_reg b);
        return {op, d, a, mid, b};
    endfunction

    // fills one entry and advances the build model
    task automatic add_entry(input lc3b_word ir, input lc3b_aluop aluop, input logic lr,
                             input logic lcc, input logic [1:0] wbmux, input logic dcr,
                             input logic dcw, input logic unc, input logic [7:0] xf,
                             input logic c1, input logic c2);
        entry_t e;
        e          = '0;
        e.ir       = ir;
        e.pc       = 16'h3000 + 16'(2 * n_built);
        e.aluop    = aluop;
        e.load_reg = lr;
        e.load_cc  = lcc;
        e.wbmux    = wbmux;
        e.dcr      = dcr;
        e.dcw      = dcw;
        e.uncond   = unc;
        e.xflags   = xf;
        e.chk1     = c1;
        e.chk2     = c2;
        e.dr       = (ir[15:12] == 4'h4 || ir[15:12] == 4'hf) ? 3'd7 : ir[11:9];
        e.sr1      = ir[8:6];
        e.sr2      = (ir[15:12] == 4'h3 || ir[15:12] == 4'h7 || ir[15:12] == 4'hb) ?
                     ir[11:9] : ir[2:0];   // stores read the dr field
        e.sr1_val  = build_model[e.sr1];
        e.sr2_val  = build_model[e.sr2];
        rng        = xorshift(rng);
        e.result   = rng[15:0] | 16'h0001;
        if (lr)
            build_model[e.dr] = e.result;
        tbl[n_built] = e;
        n_built++;
    endtask

    task automatic check_val(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        assert (got === exp)
        else
        begin
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
            test_bad = 1'b1;
        end
    endtask

    task automatic check_output(input entry_t e);
        logic [7:0] xf;
        xf = {out_ctrl.div_op, out_ctrl.mult_op, out_ctrl.sub_op, out_ctrl.xor_op,
              out_ctrl.or_op, out_ctrl.nor_op, out_ctrl.xnor_op, out_ctrl.ldbse_op};
        check_val("out_ir", out_ir, e.ir);
        check_val("out_pc", out_pc, e.pc);
        check_val("aluop", 16'(out_ctrl.aluop), 16'(e.aluop));
        check_val("load_reg", 16'(out_ctrl.load_reg), 16'(e.load_reg));
        check_val("load_cc", 16'(out_ctrl.load_cc), 16'(e.load_cc));
        check_val("wbmux_sel", 16'(out_ctrl.wbmux_sel), 16'(e.wbmux));
        check_val("dcacheR", 16'(out_ctrl.dcacheR), 16'(e.dcr));
        check_val("dcacheW", 16'(out_ctrl.dcacheW), 16'(e.dcw));
        check_val("uncond_op", 16'(out_ctrl.uncond_op), 16'(e.uncond));
        check_val("lc3x flags", 16'(xf), 16'(e.xflags));
        check_val("out_dr", 16'(out_dr), 16'(e.dr));
        if (e.chk1)
        begin
            check_val("out_sr1_data", out_sr1_data, e.sr1_val);
            check_val("out_sr1_data after writeback", out_sr1_data, live_model[e.sr1]);
        end
        if (e.chk2)
        begin
            check_val("out_sr2_data", out_sr2_data, e.sr2_val);
            check_val("out_sr2_data after writeback", out_sr2_data, live_model[e.sr2]);
        end
        // a source must not still wait on its writeback
        foreach (wbq_dr[k])
        begin
            assert (!((e.chk1 && wbq_dr[k] == e.sr1) || (e.chk2 && wbq_dr[k] == e.sr2)))
            else
            begin
                $display("entry left decode before the writeback of its source r%0d",
                         wbq_dr[k]);
                test_bad = 1'b1;
            end
        end
    endtask

    // execute side that checks each output and schedules its writeback
    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= LIMIT)
        begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
        else if (started)
        begin
            if (held)
            begin
                assert (out_valid && snap == {out_pc, out_ir, out_ctrl, out_sr1_data,
                                              out_sr2_data, out_dr})
                else
                begin
                    $display("outputs changed or dropped while stalled at t=%0t", $time);
                    errors++;
                end
            end
            held = out_valid && !out_ready;
            snap = {out_pc, out_ir, out_ctrl, out_sr1_data, out_sr2_data, out_dr};
            if (out_valid && out_ready)
            begin
                if (n_out >= N_ENTRIES)
                begin
                    $display("extra instruction left the stage at t=%0t", $time);
                    errors++;
                end
                else
                begin
                    test_bad = 1'b0;
                    check_output(tbl[n_out]);
                    if (tbl[n_out].load_reg)
                    begin
                        rng = xorshift(rng);
                        wbq_dr.push_back(tbl[n_out].dr);
                        wbq_data.push_back(tbl[n_out].result);
                        wbq_due.push_back(cycles + int'(rng[3:2]));   // 0..3 cycles
                    end
                    $display("test %0d ir %h: %s", n_out, tbl[n_out].ir,
                             test_bad ? "failed" : "ok");
                    if (test_bad)
                        tests_failed++;
                    n_out++;
                end
            end
        end
    end

    always @(negedge clk)
    begin
        wb_valid = 1'b0;
        if (started)
        begin
            rng       = xorshift(rng);
            out_ready = (rng[1:0] != 2'b00);
            if (wbq_dr.size() > 0 && wbq_due[0] <= cycles)
            begin
                wb_valid = 1'b1;
                wb_dr    = wbq_dr.pop_front();
                wb_data  = wbq_data.pop_front();
                void'(wbq_due.pop_front());
                live_model[wb_dr] = wb_data;
            end
        end
    end

    initial
    begin
        in_valid     = 1'b0;
        in_pc        = '0;
        in_ir        = '0;
        out_ready    = 1'b0;
        wb_valid     = 1'b0;
        wb_dr        = '0;
        wb_data      = '0;
        rng          = 32'h1d0b0031;
        cycles       = 0;
        n_out        = 0;
        n_built      = 0;
        errors       = 0;
        tests_failed = 0;
        started      = 1'b0;
        held         = 1'b0;
        test_bad     = 1'b0;
        snap         = '0;
        for (int r = 0; r < NUM_REGS; r++)
        begin
            build_model[r] = '0;
            live_model[r]  = '0;
        end

        add_entry(enc_reg(4'h1, 1, 0, 3'b100, 5), alu_add, 1, 1, 3, 0, 0, 0, 0, 1, 0);
        add_entry(enc_reg(4'h1, 2, 1, 3'b000, 1), alu_add, 1, 1, 3, 0, 0, 0, 0, 1, 1);
        add_entry(enc_reg(4'h5, 3, 2, 3'b000, 1), alu_and, 1, 1, 3, 0, 0, 0, 0, 1, 1);
        add_entry(enc_reg(4'h5, 4, 3, 3'b010, 2), alu_nand, 1, 1, 3, 0, 0, 0, 0, 1, 1);
        add_entry(enc_reg(4'h5, 5, 4, 3'b101, 0), alu_and, 1, 1, 3, 0, 0, 0, 0, 1, 0);
        add_entry(enc_reg(4'h9, 6, 5, 3'b111, 7), alu_not, 1, 1, 3, 0, 0, 0, 0, 1, 0);
        add_entry(enc_reg(4'h6, 1, 6, 3'b001, 0), alu_passa, 1, 1, 1, 1, 0, 0, 0, 1, 0);
        add_entry(enc_reg(4'h2, 2, 1, 3'b000, 2), alu_passa, 1, 1, 1, 1, 0, 0, 0, 1, 0);
        add_entry(enc_reg(4'ha, 3, 2, 3'b000, 4), alu_passa, 1, 1, 1, 1, 0, 0, 0, 1, 0);
        add_entry(enc_reg(4'h7, 3, 4, 3'b000, 1), alu_passb, 0, 0, 0, 0, 1, 0, 0, 1, 1);
        add_entry(enc_reg(4'h3, 2, 5, 3'b000, 3), alu_passb, 0, 0, 0, 0, 1, 0, 0, 1, 1);
        add_entry(enc_reg(4'hb, 1, 6, 3'b000, 2), alu_passb, 0, 0, 0, 0, 1, 0, 0, 1, 1);
        add_entry(16'h0e38, alu_passa, 0, 0, 0, 0, 0, 0, 0, 0, 0);    // brnzp
        add_entry(enc_reg(4'hc, 0, 3, 3'b000, 0), alu_passa, 0, 0, 0, 0, 0, 1, 0, 1, 0);
        add_entry(16'h4810, alu_passa, 1, 0, 2, 0, 0, 1, 0, 0, 0);    // jsr
        add_entry(enc_reg(4'h4, 0, 2, 3'b000, 0), alu_passa, 1, 0, 2, 0, 0, 1, 0, 1, 0);
        add_entry(16'hf025, alu_passa, 1, 0, 2, 1, 0, 1, 0, 0, 0);    // trap x25
        add_entry(enc_reg(4'h8, 1, 2, 3'b000, 3), alu_div, 1, 1, 3, 0, 0, 0, 8'h80, 1, 1);
        add_entry(enc_reg(4'h8, 2, 1, 3'b001, 3), alu_mult, 1, 1, 3, 0, 0, 0, 8'h40, 1, 1);
        add_entry(enc_reg(4'h8, 3, 1, 3'b010, 2), alu_sub, 1, 1, 3, 0, 0, 0, 8'h20, 1, 1);
        add_entry(enc_reg(4'h8, 4, 3, 3'b011, 2), alu_xor, 1, 1, 3, 0, 0, 0, 8'h10, 1, 1);
        add_entry(enc_reg(4'h8, 5, 4, 3'b100, 3), alu_or, 1, 1, 3, 0, 0, 0, 8'h08, 1, 1);
        add_entry(enc_reg(4'h8, 6, 5, 3'b101, 4), alu_passa, 1, 1, 3, 0, 0, 0, 8'h04, 1, 1);
        add_entry(enc_reg(4'h8, 1, 6, 3'b110, 5), alu_passa, 1, 1, 3, 0, 0, 0, 8'h02, 1, 1);
        add_entry(enc_reg(4'h8, 2, 1, 3'b111, 0), alu_passa, 1, 1, 1, 1, 0, 0, 8'h01, 1, 0);

        wait (arst_n === 1'b1);
        @(negedge clk);
        test_bad = 1'b0;
        check_val("out_valid", 16'(out_valid), 16'd0);
        check_val("in_ready", 16'(in_ready), 16'd1);
        $display("test reset: %s", test_bad ? "failed" : "ok");
        if (test_bad)
            tests_failed++;
        started <= 1'b1;

        // fetch side holds each entry until its handshake
        for (int i = 0; i < N_ENTRIES; i++)
        begin
            in_valid = 1'b1;
            in_pc    = tbl[i].pc;
            in_ir    = tbl[i].ir;
            do
                @(posedge clk);
            while (!in_ready);
            @(negedge clk);
        end
        in_valid = 1'b0;

        while (!(n_out == N_ENTRIES && wbq_dr.size() == 0))
            @(negedge clk);
        repeat (3) @(negedge clk);
        $display("%0d tests, %0d passed, %0d failed, %0d other errors", N_ENTRIES + 1,
                 N_ENTRIES + 1 - tests_failed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule : decode_stage_tb

`default_nettype wire

// ==== decode_stage.f ====
hw/lc3b_types.sv
hw/pipe_reg.sv
hw/control_rom.sv
hw/regfile.sv
hw/scoreboard.sv
hw/decode_core.sv
hw/decode_stage.sv
test/tb_clock.sv
test/decode_stage_tb.sv
